// File: design/sidPkg.sv
package sidPkg;

  localparam int numVoices   = 3;
  localparam int voiceStride = 7;   // register spacing between voices

  // widths
  localparam int accWidth  = 24;
  localparam int waveWidth = 12;
  localparam int envWidth  = 8;
  localparam int outWidth  = 16;

  typedef logic        [4:0]           regAddrT;
  typedef logic        [7:0]           regDataT;
  typedef logic        [15:0]          freqT;
  typedef logic        [11:0]          pwT;
  typedef logic        [waveWidth-1:0] waveT;
  typedef logic        [envWidth-1:0]  envT;
  typedef logic        [3:0]           rateT;
  typedef logic        [3:0]           volT;
  typedef logic signed [outWidth-1:0]  sampleT;

  // per-voice offsets from the voice base
  localparam int offFreqLo         = 0;
  localparam int offFreqHi         = 1;
  localparam int offPwLo           = 2;
  localparam int offPwHi           = 3;   // low nibble only
  localparam int offControl        = 4;   // gate, test, tri, saw, pulse
  localparam int offAttackDecay    = 5;
  localparam int offSustainRelease = 6;

  // global registers
  localparam regAddrT addrModeVol = 5'h18;
  localparam regAddrT addrOsc3    = 5'h1b;
  localparam regAddrT addrEnv3    = 5'h1c;

  // clkEn ticks per attack step, decay and release take 3x
  localparam logic [15:0] envRatePeriods [16] = '{
    16'd2,   16'd8,   16'd16,  16'd24,
    16'd38,  16'd56,  16'd68,  16'd80,
    16'd100, 16'd250, 16'd500, 16'd800,
    16'd1000, 16'd3000, 16'd5000, 16'd8000
  };

endpackage

// File: design/sidRegs.sv
`timescale 1ns/1ps

module sidRegs (
  input  logic            clk,
  input  logic            arstN,
  input  logic            we,
  input  sidPkg::regAddrT addr,
  input  sidPkg::regDataT dataW,
  input  sidPkg::waveT    osc3Wave,
  input  sidPkg::envT     env3,
  output sidPkg::freqT    freq        [sidPkg::numVoices],
  output sidPkg::pwT      pulseWidth  [sidPkg::numVoices],
  output logic [2:0]      waveSel     [sidPkg::numVoices],
  output logic            testBit     [sidPkg::numVoices],
  output logic            gate        [sidPkg::numVoices],
  output sidPkg::rateT    attack      [sidPkg::numVoices],
  output sidPkg::rateT    decay       [sidPkg::numVoices],
  output sidPkg::rateT    sustain     [sidPkg::numVoices],
  output sidPkg::rateT    releaseRate [sidPkg::numVoices],
  output sidPkg::volT     volume,
  output logic            voice3Off,
  output sidPkg::regDataT dataR
);

  localparam int idxWidth = $clog2(sidPkg::numVoices);

  logic                isVoice;
  logic [idxWidth-1:0] voiceIdx;
  sidPkg::regAddrT     voiceOff;   // address relative to the voice base
  sidPkg::regDataT     lastWrite;

  // find which voice block the address falls in
  always_comb begin
    isVoice  = 1'b0;
    voiceIdx = '0;
    voiceOff = addr;
    for (int v = 0; v < sidPkg::numVoices; v++) begin
      if (int'(addr) >= v * sidPkg::voiceStride &&
          int'(addr) < (v + 1) * sidPkg::voiceStride) begin
        isVoice  = 1'b1;
        voiceIdx = idxWidth'(v);
        voiceOff = sidPkg::regAddrT'(int'(addr) - v * sidPkg::voiceStride);
      end
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int v = 0; v < sidPkg::numVoices; v++) begin
        freq[v]        <= '0;
        pulseWidth[v]  <= '0;
        waveSel[v]     <= '0;
        testBit[v]     <= 1'b0;
        gate[v]        <= 1'b0;
        attack[v]      <= '0;
        decay[v]       <= '0;
        sustain[v]     <= '0;
        releaseRate[v] <= '0;
      end
      volume    <= '0;
      voice3Off <= 1'b0;
      lastWrite <= '0;
    end else if (we) begin
      lastWrite <= dataW;   // any write, for readback
      if (isVoice) begin
        case (int'(voiceOff))
          sidPkg::offFreqLo: freq[voiceIdx][7:0]        <= dataW;
          sidPkg::offFreqHi: freq[voiceIdx][15:8]       <= dataW;
          sidPkg::offPwLo:   pulseWidth[voiceIdx][7:0]  <= dataW;
          sidPkg::offPwHi:   pulseWidth[voiceIdx][11:8] <= dataW[3:0];
          sidPkg::offControl: begin
            gate[voiceIdx]    <= dataW[0];
            testBit[voiceIdx] <= dataW[3];
            waveSel[voiceIdx] <= dataW[6:4];   // tri, saw, pulse
          end
          sidPkg::offAttackDecay: begin
            attack[voiceIdx] <= dataW[7:4];
            decay[voiceIdx]  <= dataW[3:0];
          end
          sidPkg::offSustainRelease: begin
            sustain[voiceIdx]     <= dataW[7:4];
            releaseRate[voiceIdx] <= dataW[3:0];
          end
          default: ;
        endcase
      end else if (addr == sidPkg::addrModeVol) begin
        volume    <= dataW[3:0];
        voice3Off <= dataW[7];
      end
    end
  end

  // write-only registers read back the last written byte
  always_comb begin
    case (addr)
      sidPkg::addrOsc3: dataR = osc3Wave[sidPkg::waveWidth-1 -: 8];   // osc3 msbs
      sidPkg::addrEnv3: dataR = env3;
      default:          dataR = lastWrite;
    endcase
  end

endmodule

// File: design/sidVoice.sv
`timescale 1ns/1ps

module sidVoice (
  input  logic         clk,
  input  logic         arstN,
  input  logic         clkEn,
  input  sidPkg::freqT freq,
  input  sidPkg::pwT   pulseWidth,
  input  logic [2:0]   waveSel,      // bit 0 tri, bit 1 saw, bit 2 pulse
  input  logic         testBit,
  output sidPkg::waveT wave
);

  localparam int accTop = sidPkg::accWidth - 1;

  logic [sidPkg::accWidth-1:0] acc;
  sidPkg::waveT                triWave;
  sidPkg::waveT                sawWave;
  sidPkg::waveT                pulseWave;
  sidPkg::waveT                mixWave;

  // phase accumulator
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      acc <= '0;
    end else if (testBit) begin
      acc <= '0;   // held while test is set
    end else if (clkEn) begin
      acc <= acc + sidPkg::accWidth'(freq);
    end
  end

  always_comb begin
    sawWave   = acc[accTop -: sidPkg::waveWidth];
    // fold the ramp back down in the upper half
    triWave   = acc[accTop-1 -: sidPkg::waveWidth] ^ {sidPkg::waveWidth{acc[accTop]}};
    pulseWave = (acc[accTop -: sidPkg::waveWidth] >= pulseWidth) ? '1 : '0;

    // combined waveforms are ANDed like the chip
    mixWave = '1;
    if (waveSel[0]) begin
      mixWave = mixWave & triWave;
    end
    if (waveSel[1]) begin
      mixWave = mixWave & sawWave;
    end
    if (waveSel[2]) begin
      mixWave = mixWave & pulseWave;
    end
    if (waveSel == 3'b000) begin
      mixWave = '0;   // silent
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wave <= '0;
    end else begin
      wave <= mixWave;
    end
  end

endmodule

// File: design/sidEnvelope.sv
`timescale 1ns/1ps

module sidEnvelope (
  input  logic         clk,
  input  logic         arstN,
  input  logic         clkEn,
  input  logic         gate,
  input  sidPkg::rateT attack,
  input  sidPkg::rateT decay,
  input  sidPkg::rateT sustain,
  input  sidPkg::rateT releaseRate,
  output sidPkg::envT  env
);

  typedef enum logic [1:0] {
    stRelease,   // also idle once the level is 0
    stAttack,
    stDecay,
    stSustain
  } envStateT;

  envStateT    state;
  logic        gateDly;
  logic [15:0] prescale;
  logic [15:0] period;
  logic        stepNow;
  sidPkg::envT sustainLevel;

  assign sustainLevel = {sustain, sustain};

  // ticks per level step for the current phase
  always_comb begin
    case (state)
      stAttack: period = sidPkg::envRatePeriods[attack];
      stDecay:  period = 16'(3 * sidPkg::envRatePeriods[decay]);
      default:  period = 16'(3 * sidPkg::envRatePeriods[releaseRate]);
    endcase
  end

  assign stepNow = (prescale == period - 16'd1);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= stRelease;
      gateDly  <= 1'b0;
      prescale <= '0;
      env      <= '0;
    end else begin
      gateDly <= gate;
      if (gate && !gateDly) begin
        state    <= stAttack;   // restart from current level
        prescale <= '0;
      end else if (!gate && gateDly) begin
        state    <= stRelease;
        prescale <= '0;
      end else if (clkEn) begin
        case (state)
          stAttack: begin
            if (env == '1) begin
              state <= stDecay;   // regate at full level
            end else if (stepNow) begin
              prescale <= '0;
              env      <= env + 1'b1;
              if (env == 8'hfe) begin
                state <= stDecay;
              end
            end else begin
              prescale <= prescale + 1'b1;
            end
          end

          stDecay: begin
            if (env == sustainLevel || env == '0) begin
              state    <= stSustain;
              prescale <= '0;
            end else if (stepNow) begin
              prescale <= '0;
              env      <= env - 1'b1;
              if (env - 1'b1 == sustainLevel) begin
                state <= stSustain;
              end
            end else begin
              prescale <= prescale + 1'b1;
            end
          end

          stSustain: begin
            prescale <= '0;   // level holds while gated
          end

          default: begin
            if (env == '0) begin
              prescale <= '0;
            end else if (stepNow) begin
              prescale <= '0;
              env      <= env - 1'b1;
            end else begin
              prescale <= prescale + 1'b1;
            end
          end
        endcase
      end
    end
  end

endmodule

// File: design/sidMixer.sv
`timescale 1ns/1ps

module sidMixer (
  input  logic           clk,
  input  logic           arstN,
  input  sidPkg::waveT   wave [sidPkg::numVoices],
  input  sidPkg::envT    env  [sidPkg::numVoices],
  input  logic           voice3Off,
  input  sidPkg::volT    volume,
  output sidPkg::sampleT audioOut
);

  // 12b signed times 9b positive
  localparam int prodWidth  = sidPkg::waveWidth + sidPkg::envWidth + 1;
  localparam int sumWidth   = prodWidth + 2;
  localparam int scaleWidth = sidPkg::outWidth + 5;

  localparam logic signed [sumWidth-1:0] posLimit = sumWidth'(32767);
  localparam logic signed [sumWidth-1:0] negLimit = sumWidth'(-32768);

  logic signed [sidPkg::waveWidth-1:0] voiceSigned [sidPkg::numVoices];
  logic signed [prodWidth-1:0]         prod        [sidPkg::numVoices];
  logic signed [sumWidth-1:0]          sum;
  logic signed [sumWidth-1:0]          sumShift;
  sidPkg::sampleT                      clipped;
  sidPkg::sampleT                      clippedReg;
  logic signed [scaleWidth-1:0]        scaled;
  logic signed [scaleWidth-1:0]        scaledShift;

  // offset binary to two's complement
  always_comb begin
    for (int v = 0; v < sidPkg::numVoices; v++) begin
      voiceSigned[v] = {~wave[v][sidPkg::waveWidth-1], wave[v][sidPkg::waveWidth-2:0]};
    end
  end

  // stage 1 multiplying DAC per voice
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int v = 0; v < sidPkg::numVoices; v++) begin
        prod[v] <= '0;
      end
    end else begin
      for (int v = 0; v < sidPkg::numVoices; v++) begin
        prod[v] <= voiceSigned[v] * $signed({1'b0, env[v]});
      end
    end
  end

  always_comb begin
    sum = prod[0] + prod[1];
    if (!voice3Off) begin
      sum = sum + prod[2];   // voice 3 unless disconnected
    end
    sumShift = sum >>> 4;
    if (sumShift > posLimit) begin
      clipped = 16'sh7fff;
    end else if (sumShift < negLimit) begin
      clipped = -16'sh8000;
    end else begin
      clipped = sidPkg::sampleT'(sumShift);
    end
  end

  // master volume as a 16x4 DAC
  assign scaled      = clippedReg * $signed({1'b0, volume});
  assign scaledShift = scaled >>> 4;

  // stage 2 clip, stage 3 volume
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      clippedReg <= '0;
      audioOut   <= '0;
    end else begin
      clippedReg <= clipped;
      audioOut   <= sidPkg::sampleT'(scaledShift);
    end
  end

endmodule

// File: design/sidTop.sv
`timescale 1ns/1ps

module sidTop (
  input  logic            clk,
  input  logic            arstN,
  input  logic            clkEn,        // oscillator and envelope pacing
  input  logic            we,
  input  sidPkg::regAddrT addr,
  input  sidPkg::regDataT dataW,
  output sidPkg::regDataT dataR,
  output sidPkg::sampleT  audioOut
);

  sidPkg::freqT freq        [sidPkg::numVoices];
  sidPkg::pwT   pulseWidth  [sidPkg::numVoices];
  logic [2:0]   waveSel     [sidPkg::numVoices];
  logic         testBit     [sidPkg::numVoices];
  logic         gate        [sidPkg::numVoices];
  sidPkg::rateT attack      [sidPkg::numVoices];
  sidPkg::rateT decay       [sidPkg::numVoices];
  sidPkg::rateT sustain     [sidPkg::numVoices];
  sidPkg::rateT releaseRate [sidPkg::numVoices];
  sidPkg::waveT wave        [sidPkg::numVoices];
  sidPkg::envT  env         [sidPkg::numVoices];
  sidPkg::volT  volume;
  logic         voice3Off;

  sidRegs iRegs (
    .clk         (clk),
    .arstN       (arstN),
    .we          (we),
    .addr        (addr),
    .dataW       (dataW),
    .osc3Wave    (wave[2]),    // voice 3 readback
    .env3        (env[2]),
    .freq        (freq),
    .pulseWidth  (pulseWidth),
    .waveSel     (waveSel),
    .testBit     (testBit),
    .gate        (gate),
    .attack      (attack),
    .decay       (decay),
    .sustain     (sustain),
    .releaseRate (releaseRate),
    .volume      (volume),
    .voice3Off   (voice3Off),
    .dataR       (dataR)
  );

  for (genvar v = 0; v < sidPkg::numVoices; v++) begin : genVoice
    sidVoice iVoice (
      .clk        (clk),
      .arstN      (arstN),
      .clkEn      (clkEn),
      .freq       (freq[v]),
      .pulseWidth (pulseWidth[v]),
      .waveSel    (waveSel[v]),
      .testBit    (testBit[v]),
      .wave       (wave[v])
    );

    sidEnvelope iEnv (
      .clk         (clk),
      .arstN       (arstN),
      .clkEn       (clkEn),
      .gate        (gate[v]),
      .attack      (attack[v]),
      .decay       (decay[v]),
      .sustain     (sustain[v]),
      .releaseRate (releaseRate[v]),
      .env         (env[v])
    );
  end

  sidMixer iMixer (
    .clk       (clk),
    .arstN     (arstN),
    .wave      (wave),
    .env       (env),
    .voice3Off (voice3Off),
    .volume    (volume),
    .audioOut  (audioOut)
  );

endmodule

// File: tb/tbClock.sv
`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic arstN
);

  localparam int halfPeriod  = 4;    // 8 ns period
  localparam int resetCycles = 16;

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  initial begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1 arstN = 1'b1;   // release just after an edge
  end

endmodule

// File: tb/sidTb.sv
`timescale 1ns/1ps

module sidTb;

  typedef enum logic [1:0] {writeOp, waitOp, readOp, outputOp} opT;

  typedef struct packed {
    opT              op;
    sidPkg::regAddrT addr;
    sidPkg::regDataT data;
    logic [31:0]     ticks;
    logic [15:0]     expected;
  } entryT;

  localparam int cyclesPerTick = 4;
  localparam int clkPeriodNs   = 8;
  localparam int attackStep    = 2;   // attack rate 0
  localparam int fallStep      = 6;   // decay and release rate 0

  logic            clk;
  logic            arstN;
  logic            clkEn;
  logic            we;
  sidPkg::regAddrT addr;
  sidPkg::regDataT dataW;
  sidPkg::regDataT dataR;
  sidPkg::sampleT  audioOut;

  entryT       stimTable [$];
  string       names [$];
  logic [31:0] lfsr;
  longint      totalTicks;
  longint      watchdogNs;
  logic        tableReady;

  tbClock iClock (.clk(clk), .arstN(arstN));

  sidTop i_dut (
    .clk      (clk),
    .arstN    (arstN),
    .clkEn    (clkEn),
    .we       (we),
    .addr     (addr),
    .dataW    (dataW),
    .dataR    (dataR),
    .audioOut (audioOut)
  );

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic nextBit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] drawBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], nextBit()};
    end
    return v;
  endfunction

  function automatic logic [23:0] accAfter(input sidPkg::freqT f, input int k);
    return 24'(32'(f) * 32'(k));   // wraps at 2^24
  endfunction

  function automatic sidPkg::regDataT sawExpect(input sidPkg::freqT f, input int k);
    logic [23:0] acc;
    acc = accAfter(f, k);
    return acc[23:16];
  endfunction

  function automatic sidPkg::regDataT triExpect(input sidPkg::freqT f, input int k);
    logic [23:0] acc;
    acc = accAfter(f, k);
    return acc[22:15] ^ {8{acc[23]}};
  endfunction

  function automatic sidPkg::regDataT pulseExpect(input sidPkg::freqT f, input sidPkg::pwT pw,
                                                  input int k);
    logic [23:0] acc;
    acc = accAfter(f, k);
    return (acc[23:12] >= pw) ? 8'hff : 8'h00;
  endfunction

  // attack from 0 then decay toward the sustain level
  function automatic sidPkg::envT attackDecayLevel(input int ticks, input int sus);
    int full;
    int lvl;
    full = 255 * attackStep;
    if (ticks < full) begin
      return sidPkg::envT'(ticks / attackStep);
    end
    lvl = 255 - (ticks - full) / fallStep;
    return sidPkg::envT'((lvl < sus * 17) ? sus * 17 : lvl);
  endfunction

  function automatic sidPkg::envT releaseLevel(input int start, input int ticks);
    int lvl;
    lvl = start - ticks / fallStep;
    return sidPkg::envT'((lvl < 0) ? 0 : lvl);
  endfunction

  function automatic sidPkg::sampleT mixRule(input sidPkg::waveT w, input sidPkg::envT e0,
                                             input sidPkg::envT e1, input sidPkg::envT e2,
                                             input logic v3Off, input sidPkg::volT vol);
    int sv;
    int sum;
    sv  = int'(w) - 2048;   // offset binary to signed
    sum = sv * int'(e0) + sv * int'(e1);
    if (!v3Off) begin
      sum = sum + sv * int'(e2);
    end
    sum = sum >>> 4;
    if (sum > 32767) begin
      sum = 32767;
    end else if (sum < -32768) begin
      sum = -32768;
    end
    return sidPkg::sampleT'((sum * int'(vol)) >>> 4);
  endfunction

  task automatic addEntry(input string name, input opT op, input sidPkg::regAddrT a,
                          input sidPkg::regDataT d, input int ticks, input logic [15:0] exp);
    entryT e;
    e.op       = op;
    e.addr     = a;
    e.data     = d;
    e.ticks    = 32'(ticks);
    e.expected = exp;
    stimTable.push_back(e);
    names.push_back(name);
    totalTicks += ticks;
  endtask

  task automatic addWrite(input sidPkg::regAddrT a, input sidPkg::regDataT d);
    addEntry("write", writeOp, a, d, 0, '0);
  endtask

  task automatic addWait(input int ticks);
    addEntry("wait", waitOp, '0, '0, ticks, '0);
  endtask

  task automatic addFreq3(input sidPkg::freqT f);
    addWrite(5'h0e, f[7:0]);
    addWrite(5'h0f, f[15:8]);
  endtask

  task automatic buildTable();
    sidPkg::regDataT rb;
    sidPkg::freqT    f;
    sidPkg::pwT      pw;
    addEntry("reset audio", outputOp, '0, '0, 0, '0);
    rb = sidPkg::regDataT'(drawBits(8));
    addWrite(5'h05, rb);
    addEntry("readback 0x05", readOp, 5'h05, '0, 0, 16'(rb));
    addEntry("readback 0x19", readOp, 5'h19, '0, 0, 16'(rb));
    addEntry("readback 0x17", readOp, 5'h17, '0, 0, 16'(rb));
    // voice 3 sawtooth, triangle and pulse from a held-zero start
    f = sidPkg::freqT'(drawBits(16));
    addWrite(5'h12, 8'h28);
    addFreq3(f);
    addWrite(5'h12, 8'h20);
    addWait(37);
    addEntry("osc3 saw 37", readOp, sidPkg::addrOsc3, '0, 0, 16'(sawExpect(f, 37)));
    addWait(20);
    addEntry("osc3 saw 57", readOp, sidPkg::addrOsc3, '0, 0, 16'(sawExpect(f, 57)));
    f = sidPkg::freqT'(drawBits(16));
    addWrite(5'h12, 8'h18);
    addFreq3(f);
    addWrite(5'h12, 8'h10);
    addWait(45);
    addEntry("osc3 tri 45", readOp, sidPkg::addrOsc3, '0, 0, 16'(triExpect(f, 45)));
    f  = sidPkg::freqT'(drawBits(16));
    pw = sidPkg::pwT'(drawBits(12));
    addWrite(5'h12, 8'h48);
    addFreq3(f);
    addWrite(5'h10, pw[7:0]);
    addWrite(5'h11, {4'h0, pw[11:8]});
    addWrite(5'h12, 8'h40);
    addWait(29);
    addEntry("osc3 pulse 29", readOp, sidPkg::addrOsc3, '0, 0, 16'(pulseExpect(f, pw, 29)));
    addWait(2971);   // far enough for the phase to pass the pulse width
    addEntry("osc3 pulse 3000", readOp, sidPkg::addrOsc3, '0, 0,
             16'(pulseExpect(f, pw, 3000)));
    // envelope 3 attack with sustain 15
    addWrite(5'h13, 8'h00);
    addWrite(5'h14, 8'hf0);
    addWrite(5'h12, 8'h21);
    addWait(100);
    addEntry("env3 attack 100", readOp, sidPkg::addrEnv3, '0, 0, 16'(attackDecayLevel(100, 15)));
    addWait(37);
    addEntry("env3 attack 137", readOp, sidPkg::addrEnv3, '0, 0, 16'(attackDecayLevel(137, 15)));
    addWait(500);
    addEntry("env3 hold 255", readOp, sidPkg::addrEnv3, '0, 0, 16'(attackDecayLevel(637, 15)));
    addWrite(5'h12, 8'h20);
    addWait(1600);
    addEntry("env3 release 255", readOp, sidPkg::addrEnv3, '0, 0, 16'(releaseLevel(255, 1600)));
    // decay to sustain 8, then release
    addWrite(5'h14, 8'h80);
    addWrite(5'h12, 8'h21);
    addWait(1224);
    addEntry("env3 decay 0x88", readOp, sidPkg::addrEnv3, '0, 0, 16'(attackDecayLevel(1224, 8)));
    addWrite(5'h12, 8'h20);
    addWait(60);
    addEntry("env3 release 60", readOp, sidPkg::addrEnv3, '0, 0, 16'(releaseLevel(136, 60)));
    addWait(840);
    addEntry("env3 release 900", readOp, sidPkg::addrEnv3, '0, 0, 16'(releaseLevel(136, 900)));
    // all voices at full scale
    for (int v = 0; v < 3; v++) begin
      addWrite(sidPkg::regAddrT'(v * 7 + 5), 8'h00);
      addWrite(sidPkg::regAddrT'(v * 7 + 6), 8'hf0);
      addWrite(sidPkg::regAddrT'(v * 7 + 4), 8'h29);
    end
    addWrite(sidPkg::addrModeVol, 8'h0f);
    addWait(520);
    addEntry("full scale vol 15", outputOp, '0, '0, 0,
             mixRule(12'h000, 8'hff, 8'hff, 8'hff, 1'b0, 4'hf));
    addWrite(sidPkg::addrModeVol, 8'h00);
    addEntry("full scale vol 0", outputOp, '0, '0, 0,
             mixRule(12'h000, 8'hff, 8'hff, 8'hff, 1'b0, 4'h0));
    // only voice 3 stays gated
    addWrite(5'h04, 8'h28);
    addWrite(5'h0b, 8'h28);
    addWait(1600);
    addWrite(sidPkg::addrModeVol, 8'h8f);
    addEntry("voice3 off", outputOp, '0, '0, 0,
             mixRule(12'h000, 8'h00, 8'h00, 8'hff, 1'b1, 4'hf));
    addWrite(sidPkg::addrModeVol, 8'h0f);
    addEntry("voice3 on", outputOp, '0, '0, 0,
             mixRule(12'h000, 8'h00, 8'h00, 8'hff, 1'b0, 4'hf));
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic checkData(input string name, input sidPkg::regDataT exp,
                           input sidPkg::regDataT act);
    if (act !== exp) begin
      $display("** Error %s: expected 0x%02h, actual 0x%02h", name, exp, act);
      $display("Regression failed");
      $fatal(1, "readback mismatch");
    end
  endtask

  task automatic checkSample(input string name, input sidPkg::sampleT exp,
                             input sidPkg::sampleT act);
    if (act !== exp) begin
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      $display("Regression failed");
      $fatal(1, "audio mismatch");
    end
  endtask

  task automatic applyEntry(input int i);
    entryT e;
    e = stimTable[i];
    case (e.op)
      writeOp: begin
        we    = 1'b1;
        addr  = e.addr;
        dataW = e.data;
        nextCycle();
        we = 1'b0;
        nextCycle();   // let gate edges settle before ticks
        nextCycle();
      end
      waitOp: begin
        repeat (e.ticks) begin
          clkEn = 1'b1;
          nextCycle();
          clkEn = 1'b0;
          repeat (cyclesPerTick - 1) nextCycle();
        end
      end
      readOp: begin
        addr = e.addr;
        #1;
        checkData(names[i], e.expected[7:0], dataR);
      end
      default: begin
        repeat (3) nextCycle();   // mixer pipeline depth
        checkSample(names[i], sidPkg::sampleT'(e.expected), audioOut);
      end
    endcase
  endtask

  initial begin
    clkEn      = 1'b0;
    we         = 1'b0;
    addr       = '0;
    dataW      = '0;
    lfsr       = 32'hec38;
    totalTicks = 0;
    tableReady = 1'b0;
    buildTable();
    watchdogNs = totalTicks * cyclesPerTick * clkPeriodNs * 2
               + longint'(stimTable.size()) * 8 * clkPeriodNs + 2000;
    tableReady = 1'b1;
    wait (arstN === 1'b1);
    nextCycle();
    for (int i = 0; i < stimTable.size(); i++) begin
      applyEntry(i);
    end
    $display("Regression passed");
    $finish;
  end

  initial begin
    wait (tableReady === 1'b1);
    #(watchdogNs);
    $display("Regression failed");
    $display("watchdog: the stimulus table did not finish within %0d ns", watchdogNs);
    $fatal(1, "timeout");
  end

endmodule

// File: verilog.f
design/sidPkg.sv
design/sidRegs.sv
design/sidVoice.sv
design/sidEnvelope.sv
design/sidMixer.sv
design/sidTop.sv
tb/tbClock.sv
tb/sidTb.sv

// File: run.sh
#!/bin/sh
# build and run the sound generator testbench with verilator

if ! verilator --binary --timing -Wno-fatal --top-module sidTb -f verilog.f \
    -Mdir obj_dir -o simv; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Regression passed$"; then
  exit 0
fi
exit 1
